//--- all.f
rtl/pipe_lane_pkg.sv
rtl/ordered_set_pkg.sv
rtl/os_symbol_decode.sv
rtl/os_lane_assembler.sv
rtl/os_lane_result.sv
rtl/pipe_rx_os_top.sv
sim/pipe_rx_os_checker.sv
sim/pipe_rx_os_tb.sv

//--- rtl/ordered_set_pkg.sv
`default_nettype none

package ordered_set_pkg;

  // TS1/TS2 length in symbols, COM included
  localparam int os_len = 16;

  // Consecutive idle data symbols that make one idle set
  localparam int idle_run_len = 8;

  // Identifiers of symbols 6 to 15
  localparam logic [7:0] ts1_id = 8'h4A;
  localparam logic [7:0] ts2_id = 8'h45;

  typedef enum logic [1:0] {
    OS_NONE,
    OS_TS1,
    OS_TS2,
    OS_IDLE
  } os_kind_e;

  // Record fields, PAD is kept as its K code
  typedef logic [7:0] link_num_t;
  typedef logic [7:0] lane_num_t;
  typedef logic [7:0] rate_id_t;
  typedef logic [7:0] train_ctrl_t;

  typedef logic [3:0] sym_idx_t;

  // Saturates at all ones
  typedef logic [7:0] err_cnt_t;

endpackage

`default_nettype wire

//--- rtl/os_lane_assembler.sv
`default_nettype none

module os_lane_assembler (
  input  wire logic                                                      pipe_rx_usr_clk_i,
  input  wire logic                                                      arst_n_i,
  input  pipe_lane_pkg::sym_class_e    [pipe_lane_pkg::num_lanes-1:0]   sym_class_i,
  input  pipe_lane_pkg::sym_t          [pipe_lane_pkg::num_lanes-1:0]   sym_i,
  output pipe_lane_pkg::lane_mask_t                                      set_done_o,
  output ordered_set_pkg::os_kind_e    [pipe_lane_pkg::num_lanes-1:0]   set_kind_o,
  output ordered_set_pkg::link_num_t   [pipe_lane_pkg::num_lanes-1:0]   set_link_o,
  output ordered_set_pkg::lane_num_t   [pipe_lane_pkg::num_lanes-1:0]   set_lane_o,
  output ordered_set_pkg::rate_id_t    [pipe_lane_pkg::num_lanes-1:0]   set_rate_o,
  output ordered_set_pkg::train_ctrl_t [pipe_lane_pkg::num_lanes-1:0]   set_train_o,
  output pipe_lane_pkg::lane_mask_t                                      set_bad_o
);

  import pipe_lane_pkg::*;
  import ordered_set_pkg::*;

  typedef enum logic {
    HUNT,
    COLLECT
  } asm_state_e;

  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    asm_state_e  state_q;
    sym_idx_t    idx_q;
    sym_idx_t    idle_cnt_q;
    os_kind_e    kind_q;
    os_kind_e    set_kind_q;
    link_num_t   link_q;
    lane_num_t   lane_q;
    rate_id_t    rate_q;
    train_ctrl_t train_q;
    logic        done_q;
    logic        bad_q;
    logic        is_data;
    logic        sym_ok;
    logic        take;
    logic        ts_done;
    logic        idle_done;
    logic [7:0]  exp_id;

    assign is_data = (sym_class_i[l] == SYM_DATA) || (sym_class_i[l] == SYM_IDLE_DATA);
    assign exp_id  = (kind_q == OS_TS2) ? ts2_id : ts1_id;

    // Symbol check by position within the set
    always_comb begin
      case (idx_q)
        4'd1, 4'd2: sym_ok = is_data || (sym_class_i[l] == SYM_PAD);
        4'd3, 4'd4, 4'd5: sym_ok = is_data;
        4'd6: sym_ok = is_data && ((sym_i[l] == ts1_id) || (sym_i[l] == ts2_id));
        default: sym_ok = is_data && (sym_i[l] == exp_id);
      endcase
    end

    assign take = (state_q == COLLECT) && (sym_class_i[l] != SYM_NONE) &&
                  (sym_class_i[l] != SYM_COM) && sym_ok;
    assign ts_done = take && (idx_q == sym_idx_t'(os_len - 1));
    assign idle_done = (state_q == HUNT) && (sym_class_i[l] == SYM_IDLE_DATA) &&
                       (idle_cnt_q == sym_idx_t'(idle_run_len - 1));

    always_ff @(posedge pipe_rx_usr_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        state_q    <= HUNT;
        idx_q      <= '0;
        idle_cnt_q <= '0;
        done_q     <= 1'b0;
        bad_q      <= 1'b0;
      end else begin
        done_q <= ts_done || idle_done;
        bad_q  <= 1'b0;
        // A lane without a valid symbol holds everything
        if (sym_class_i[l] != SYM_NONE) begin
          if (state_q == HUNT) begin
            if (idle_done) begin
              idle_cnt_q <= '0;
            end else if (sym_class_i[l] == SYM_IDLE_DATA) begin
              idle_cnt_q <= idle_cnt_q + 1'b1;
            end else begin
              idle_cnt_q <= '0;
            end
            if (sym_class_i[l] == SYM_COM) begin
              state_q <= COLLECT;
              idx_q   <= 4'd1;
            end
          end else if (sym_class_i[l] == SYM_COM) begin
            // COM inside a set breaks it and starts the next
            bad_q <= 1'b1;
            idx_q <= 4'd1;
          end else if (!take) begin
            bad_q   <= 1'b1;
            state_q <= HUNT;
          end else begin
            idx_q <= idx_q + 1'b1;
            if (ts_done) begin
              state_q <= HUNT;
            end
          end
        end
      end
    end

    always_ff @(posedge pipe_rx_usr_clk_i) begin
      if (take) begin
        case (idx_q)
          4'd1: link_q <= sym_i[l];
          4'd2: lane_q <= sym_i[l];
          4'd4: rate_q <= sym_i[l];
          4'd5: train_q <= sym_i[l];
          4'd6: kind_q <= (sym_i[l] == ts2_id) ? OS_TS2 : OS_TS1;
          default: ;
        endcase
      end
      if (ts_done) begin
        set_kind_q <= kind_q;
      end else if (idle_done) begin
        set_kind_q <= OS_IDLE;
      end
    end

    assign set_done_o[l]  = done_q;
    assign set_bad_o[l]   = bad_q;
    assign set_kind_o[l]  = set_kind_q;
    assign set_link_o[l]  = link_q;
    assign set_lane_o[l]  = lane_q;
    assign set_rate_o[l]  = rate_q;
    assign set_train_o[l] = train_q;
  end

endmodule

`default_nettype wire

//--- rtl/os_lane_result.sv
`default_nettype none

module os_lane_result (
  input  wire logic                                                      pipe_rx_usr_clk_i,
  input  wire logic                                                      arst_n_i,
  input  pipe_lane_pkg::lane_mask_t                                      set_done_i,
  input  ordered_set_pkg::os_kind_e    [pipe_lane_pkg::num_lanes-1:0]   set_kind_i,
  input  ordered_set_pkg::link_num_t   [pipe_lane_pkg::num_lanes-1:0]   set_link_i,
  input  ordered_set_pkg::lane_num_t   [pipe_lane_pkg::num_lanes-1:0]   set_lane_i,
  input  ordered_set_pkg::rate_id_t    [pipe_lane_pkg::num_lanes-1:0]   set_rate_i,
  input  ordered_set_pkg::train_ctrl_t [pipe_lane_pkg::num_lanes-1:0]   set_train_i,
  input  pipe_lane_pkg::lane_mask_t                                      set_bad_i,
  input  pipe_lane_pkg::lane_mask_t                                      phystatus_i,
  input  pipe_lane_pkg::rxstatus_t     [pipe_lane_pkg::num_lanes-1:0]   rxstatus_i,
  input  wire logic                                                      os_ready_i,
  output logic                                                           os_valid_o,
  output ordered_set_pkg::os_kind_e                                      os_kind_o,
  output ordered_set_pkg::link_num_t                                     os_link_num_o,
  output ordered_set_pkg::lane_num_t                                     os_lane_num_o,
  output ordered_set_pkg::rate_id_t                                      os_rate_id_o,
  output ordered_set_pkg::train_ctrl_t                                   os_train_ctrl_o,
  output pipe_lane_pkg::lane_mask_t                                      os_lane_mask_o,
  output pipe_lane_pkg::lane_mask_t                                      ts1_valid_o,
  output pipe_lane_pkg::lane_mask_t                                      ts2_valid_o,
  output pipe_lane_pkg::lane_mask_t                                      idle_valid_o,
  output pipe_lane_pkg::lane_mask_t                                      lane_status_o,
  output pipe_lane_pkg::lane_cnt_t                                       num_active_lanes_o,
  output ordered_set_pkg::err_cnt_t                                      bad_count_o,
  output ordered_set_pkg::err_cnt_t                                      drop_count_o
);

  import pipe_lane_pkg::*;
  import ordered_set_pkg::*;

  lane_mask_t same_kind;
  lane_mask_t lane_status_q;
  lane_cnt_t  num_active_d;
  logic       rec_busy;
  logic       rec_load;
  logic [8:0] bad_sum;

  // Lanes that finished the same kind of set as lane 0 in this cycle
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      same_kind[i] = set_done_i[i] && (set_kind_i[i] == set_kind_i[0]);
    end
  end

  assign rec_busy = os_valid_o && !os_ready_i;
  assign rec_load = set_done_i[0] && !rec_busy;
  assign bad_sum  = {1'b0, bad_count_o} + 9'($countones(set_bad_i));

  always_comb begin
    num_active_d = '0;
    for (int i = 0; i < num_lanes; i++) begin
      if (lane_status_q[i]) begin
        num_active_d = lane_cnt_t'(i + 1);
      end
    end
  end

  always_ff @(posedge pipe_rx_usr_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      os_valid_o         <= 1'b0;
      ts1_valid_o        <= '0;
      ts2_valid_o        <= '0;
      idle_valid_o       <= '0;
      lane_status_q      <= '0;
      num_active_lanes_o <= '0;
      bad_count_o        <= '0;
      drop_count_o       <= '0;
    end else begin
      if (rec_load) begin
        os_valid_o <= 1'b1;
      end else if (os_ready_i) begin
        os_valid_o <= 1'b0;
      end
      // Pending record wins, the new one is lost
      if (set_done_i[0] && rec_busy && (drop_count_o != '1)) begin
        drop_count_o <= drop_count_o + 1'b1;
      end
      bad_count_o <= bad_sum[8] ? '1 : bad_sum[7:0];
      for (int i = 0; i < num_lanes; i++) begin
        ts1_valid_o[i]  <= set_done_i[i] && (set_kind_i[i] == OS_TS1);
        ts2_valid_o[i]  <= set_done_i[i] && (set_kind_i[i] == OS_TS2);
        idle_valid_o[i] <= set_done_i[i] && (set_kind_i[i] == OS_IDLE);
        if (phystatus_i[i] && (rxstatus_i[i] == rxstatus_rx_detected)) begin
          lane_status_q[i] <= 1'b1;
        end
      end
      num_active_lanes_o <= num_active_d;
    end
  end

  always_ff @(posedge pipe_rx_usr_clk_i) begin
    if (rec_load) begin
      os_kind_o       <= set_kind_i[0];
      os_link_num_o   <= set_link_i[0];
      os_lane_num_o   <= set_lane_i[0];
      os_rate_id_o    <= set_rate_i[0];
      os_train_ctrl_o <= set_train_i[0];
      os_lane_mask_o  <= same_kind;
    end
  end

  assign lane_status_o = lane_status_q;

endmodule

`default_nettype wire

//--- rtl/os_symbol_decode.sv
`default_nettype none

module os_symbol_decode (
  input  wire logic                                                    pipe_rx_usr_clk_i,
  input  wire logic                                                    arst_n_i,
  input  pipe_lane_pkg::sym_t       [pipe_lane_pkg::num_lanes-1:0]    rxdata_i,
  input  pipe_lane_pkg::lane_mask_t                                    rxdatak_i,
  input  pipe_lane_pkg::lane_mask_t                                    rxdata_valid_i,
  output pipe_lane_pkg::sym_class_e [pipe_lane_pkg::num_lanes-1:0]    sym_class_o,
  output pipe_lane_pkg::sym_t       [pipe_lane_pkg::num_lanes-1:0]    sym_o
);

  import pipe_lane_pkg::*;

  sym_class_e [num_lanes-1:0] sym_class_q;
  sym_t       [num_lanes-1:0] sym_q;

  function automatic sym_class_e classify(input logic valid, input logic is_k, input sym_t sym);
    sym_class_e cls;
    if (!valid) begin
      cls = SYM_NONE;
    end else if (is_k) begin
      if (sym == k_com) begin
        cls = SYM_COM;
      end else if (sym == k_pad) begin
        cls = SYM_PAD;
      end else begin
        cls = SYM_K_OTHER;
      end
    end else if (sym == d_idle) begin
      cls = SYM_IDLE_DATA;
    end else begin
      cls = SYM_DATA;
    end
    return cls;
  endfunction

  always_ff @(posedge pipe_rx_usr_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < num_lanes; i++) begin
        sym_class_q[i] <= SYM_NONE;
      end
    end else begin
      for (int i = 0; i < num_lanes; i++) begin
        sym_class_q[i] <= classify(rxdata_valid_i[i], rxdatak_i[i], rxdata_i[i]);
      end
    end
  end

  // Symbol value only matters where the class says so
  always_ff @(posedge pipe_rx_usr_clk_i) begin
    sym_q <= rxdata_i;
  end

  assign sym_class_o = sym_class_q;
  assign sym_o       = sym_q;

endmodule

`default_nettype wire

//--- rtl/pipe_lane_pkg.sv
`default_nettype none

package pipe_lane_pkg;

  // Four lanes, Gen1/Gen2 PIPE width of one symbol per lane
  localparam int num_lanes = 4;

  typedef logic [7:0] sym_t;
  typedef logic [2:0] rxstatus_t;
  typedef logic [num_lanes-1:0] lane_mask_t;

  // Holds 0 to num_lanes
  typedef logic [2:0] lane_cnt_t;

  localparam rxstatus_t rxstatus_rx_detected = 3'b011;

  // K codes
  localparam sym_t k_com = 8'hBC;
  localparam sym_t k_pad = 8'hF7;

  // Logical idle data symbol
  localparam sym_t d_idle = 8'h00;

  typedef enum logic [2:0] {
    SYM_DATA,
    SYM_IDLE_DATA,
    SYM_COM,
    SYM_PAD,
    SYM_K_OTHER,
    SYM_NONE
  } sym_class_e;

endpackage

`default_nettype wire

//--- rtl/pipe_rx_os_top.sv
`default_nettype none

module pipe_rx_os_top (
  input  wire logic                                                    pipe_rx_usr_clk_i,
  input  wire logic                                                    arst_n_i,
  input  pipe_lane_pkg::sym_t        [pipe_lane_pkg::num_lanes-1:0]   pipe_rxdata_i,
  input  pipe_lane_pkg::lane_mask_t                                    pipe_rxdatak_i,
  input  pipe_lane_pkg::lane_mask_t                                    pipe_rxdata_valid_i,
  input  pipe_lane_pkg::lane_mask_t                                    phy_phystatus_i,
  input  pipe_lane_pkg::rxstatus_t   [pipe_lane_pkg::num_lanes-1:0]   phy_rxstatus_i,
  input  wire logic                                                    os_ready_i,
  output logic                                                         os_valid_o,
  output ordered_set_pkg::os_kind_e                                    os_kind_o,
  output ordered_set_pkg::link_num_t                                   os_link_num_o,
  output ordered_set_pkg::lane_num_t                                   os_lane_num_o,
  output ordered_set_pkg::rate_id_t                                    os_rate_id_o,
  output ordered_set_pkg::train_ctrl_t                                 os_train_ctrl_o,
  output pipe_lane_pkg::lane_mask_t                                    os_lane_mask_o,
  output pipe_lane_pkg::lane_mask_t                                    ts1_valid_o,
  output pipe_lane_pkg::lane_mask_t                                    ts2_valid_o,
  output pipe_lane_pkg::lane_mask_t                                    idle_valid_o,
  output pipe_lane_pkg::lane_mask_t                                    lane_status_o,
  output pipe_lane_pkg::lane_cnt_t                                     num_active_lanes_o,
  output ordered_set_pkg::err_cnt_t                                    bad_count_o,
  output ordered_set_pkg::err_cnt_t                                    drop_count_o
);

  import pipe_lane_pkg::*;
  import ordered_set_pkg::*;

  sym_class_e  [num_lanes-1:0] sym_class;
  sym_t        [num_lanes-1:0] sym;
  lane_mask_t                  set_done;
  lane_mask_t                  set_bad;
  os_kind_e    [num_lanes-1:0] set_kind;
  link_num_t   [num_lanes-1:0] set_link;
  lane_num_t   [num_lanes-1:0] set_lane;
  rate_id_t    [num_lanes-1:0] set_rate;
  train_ctrl_t [num_lanes-1:0] set_train;

  os_symbol_decode i_os_symbol_decode (
    .pipe_rx_usr_clk_i (pipe_rx_usr_clk_i),
    .arst_n_i          (arst_n_i),
    .rxdata_i          (pipe_rxdata_i),
    .rxdatak_i         (pipe_rxdatak_i),
    .rxdata_valid_i    (pipe_rxdata_valid_i),
    .sym_class_o       (sym_class),
    .sym_o             (sym)
  );

  os_lane_assembler i_os_lane_assembler (
    .pipe_rx_usr_clk_i (pipe_rx_usr_clk_i),
    .arst_n_i          (arst_n_i),
    .sym_class_i       (sym_class),
    .sym_i             (sym),
    .set_done_o        (set_done),
    .set_kind_o        (set_kind),
    .set_link_o        (set_link),
    .set_lane_o        (set_lane),
    .set_rate_o        (set_rate),
    .set_train_o       (set_train),
    .set_bad_o         (set_bad)
  );

  // Receiver detect goes straight from the PHY status pins
  os_lane_result i_os_lane_result (
    .pipe_rx_usr_clk_i  (pipe_rx_usr_clk_i),
    .arst_n_i           (arst_n_i),
    .set_done_i         (set_done),
    .set_kind_i         (set_kind),
    .set_link_i         (set_link),
    .set_lane_i         (set_lane),
    .set_rate_i         (set_rate),
    .set_train_i        (set_train),
    .set_bad_i          (set_bad),
    .phystatus_i        (phy_phystatus_i),
    .rxstatus_i         (phy_rxstatus_i),
    .os_ready_i         (os_ready_i),
    .os_valid_o         (os_valid_o),
    .os_kind_o          (os_kind_o),
    .os_link_num_o      (os_link_num_o),
    .os_lane_num_o      (os_lane_num_o),
    .os_rate_id_o       (os_rate_id_o),
    .os_train_ctrl_o    (os_train_ctrl_o),
    .os_lane_mask_o     (os_lane_mask_o),
    .ts1_valid_o        (ts1_valid_o),
    .ts2_valid_o        (ts2_valid_o),
    .idle_valid_o       (idle_valid_o),
    .lane_status_o      (lane_status_o),
    .num_active_lanes_o (num_active_lanes_o),
    .bad_count_o        (bad_count_o),
    .drop_count_o       (drop_count_o)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module pipe_rx_os_tb -o pipe_rx_os_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pipe_rx_os_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0

//--- sim/pipe_rx_os_checker.sv
`default_nettype none

module pipe_rx_os_checker (
  input  wire logic         pipe_rx_usr_clk_i,
  input  wire logic         os_valid_i,
  input  wire logic         os_ready_i,
  input  wire logic [1:0]   os_kind_i,
  input  wire logic [31:0]  os_fields_i,
  input  wire logic [3:0]   os_lane_mask_i,
  input  wire logic [3:0]   ts1_valid_i,
  input  wire logic [3:0]   ts2_valid_i,
  input  wire logic [3:0]   idle_valid_i,
  input  wire logic [3:0]   lane_status_i,
  input  wire logic [2:0]   num_active_lanes_i,
  input  wire logic [7:0]   bad_count_i,
  input  wire logic [7:0]   drop_count_i,
  input  wire logic         exp_push_i,
  input  wire logic [127:0] exp_name_i,
  input  wire logic [1:0]   exp_kind_i,
  input  wire logic [31:0]  exp_fields_i,
  input  wire logic [3:0]   exp_mask_i,
  input  wire logic         step_end_i,
  input  wire logic [11:0]  exp_pulses_i,
  input  wire logic [3:0]   exp_status_i,
  input  wire logic [2:0]   exp_nact_i,
  input  wire logic [7:0]   exp_bad_i,
  input  wire logic [7:0]   exp_drop_i,
  output logic [7:0]        pending_o,
  output int                error_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Idle records carry no meaningful fields
  localparam logic [1:0] kind_idle = 2'd3;

  logic [127:0] q_name[$];
  logic [1:0]   q_kind[$];
  logic [31:0]  q_fields[$];
  logic [3:0]   q_mask[$];
  logic         held = 1'b0;
  logic [37:0]  held_rec;
  // Pulse counts with one nibble each for TS1, TS2 and idle
  logic [11:0]  pulses = '0;

  initial begin
    error_count_o = 0;
    pending_o     = '0;
  end

  task automatic check_value(input logic [127:0] name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %0s %0s expected %0h actual %0h", name, what, exp, act);
      error_count_o++;
    end
  endtask

  always @(posedge pipe_rx_usr_clk_i) begin
    if (exp_push_i) begin
      q_name.push_back(exp_name_i);
      q_kind.push_back(exp_kind_i);
      q_fields.push_back(exp_fields_i);
      q_mask.push_back(exp_mask_i);
    end
    if (held && ({os_kind_i, os_fields_i, os_lane_mask_i} !== held_rec)) begin
      $display("Record changed while it waited for os_ready_i");
      error_count_o++;
    end
    held     = os_valid_i && !os_ready_i;
    held_rec = {os_kind_i, os_fields_i, os_lane_mask_i};
    if (os_valid_i && os_ready_i) begin
      if (q_kind.size() == 0) begin
        $display("A record was delivered when none was expected");
        error_count_o++;
      end else begin
        check_value(q_name[0], "kind", 32'(q_kind[0]), 32'(os_kind_i));
        check_value(q_name[0], "mask", 32'(q_mask[0]), 32'(os_lane_mask_i));
        if (q_kind[0] != kind_idle) begin
          check_value(q_name[0], "fields", q_fields[0], os_fields_i);
        end
        void'(q_name.pop_front());
        void'(q_kind.pop_front());
        void'(q_fields.pop_front());
        void'(q_mask.pop_front());
      end
    end
    pulses += {4'($countones(ts1_valid_i)), 4'($countones(ts2_valid_i)),
               4'($countones(idle_valid_i))};
    if (step_end_i) begin
      check_value(exp_name_i, "pulses", 32'(exp_pulses_i), 32'(pulses));
      check_value(exp_name_i, "lane_status", 32'(exp_status_i), 32'(lane_status_i));
      check_value(exp_name_i, "active_lanes", 32'(exp_nact_i), 32'(num_active_lanes_i));
      check_value(exp_name_i, "bad_count", 32'(exp_bad_i), 32'(bad_count_i));
      check_value(exp_name_i, "drop_count", 32'(exp_drop_i), 32'(drop_count_i));
      if (q_kind.size() != 0) begin
        $display("Test %0s ended with an expected record that never arrived", exp_name_i);
        error_count_o++;
        q_name.delete();
        q_kind.delete();
        q_fields.delete();
        q_mask.delete();
      end
      pulses = '0;
    end
    pending_o = 8'(q_kind.size());
  end

endmodule

`default_nettype wire

//--- sim/pipe_rx_os_tb.sv
`default_nettype none

module pipe_rx_os_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import pipe_lane_pkg::*;
  import ordered_set_pkg::*;

  localparam int max_steps = 64;
  localparam int drain_cycles = 4;
  localparam int record_wait = 40;
  localparam logic [7:0] filler = 8'h10;

  logic                   clk;
  logic                   arst_n;
  sym_t [num_lanes-1:0]   rxdata;
  lane_mask_t             rxdatak;
  lane_mask_t             rxvalid;
  lane_mask_t             phystatus;
  rxstatus_t [num_lanes-1:0] rxstatus;
  logic                   os_ready;

  wire logic        os_valid;
  wire logic [1:0]  os_kind;
  wire logic [7:0]  os_link;
  wire logic [7:0]  os_lane;
  wire logic [7:0]  os_rate;
  wire logic [7:0]  os_train;
  wire logic [3:0]  os_mask;
  wire logic [3:0]  ts1_valid;
  wire logic [3:0]  ts2_valid;
  wire logic [3:0]  idle_valid;
  wire logic [3:0]  lane_status;
  wire logic [2:0]  num_active;
  wire logic [7:0]  bad_count;
  wire logic [7:0]  drop_count;
  wire logic [7:0]  pending;
  int               check_errors;

  // Expectations handed to the checker
  logic         exp_push;
  logic [127:0] exp_name;
  logic [1:0]   exp_kind;
  logic [31:0]  exp_fields;
  logic [3:0]   exp_mask;
  logic         step_end;
  logic [11:0]  exp_pulses;
  logic [3:0]   exp_status;
  logic [2:0]   exp_nact;
  logic [7:0]   exp_bad;
  logic [7:0]   exp_drop;

  // Parsed test data
  logic [127:0] st_name[max_steps];
  int           st_kind[max_steps];
  logic [7:0]   st_link[max_steps];
  logic [7:0]   st_lane[max_steps];
  logic [7:0]   st_rate[max_steps];
  logic [7:0]   st_train[max_steps];
  int           st_corrupt[max_steps];
  int           st_hold[max_steps];
  int           st_exp_kind[max_steps];
  logic [3:0]   st_exp_mask[max_steps];
  int           st_d_bad[max_steps];
  int           st_d_drop[max_steps];
  int           num_steps = 0;
  int           file_lines = 0;
  int           tb_errors = 0;
  int           cycle_limit = 1000000;
  int           cycles = 0;

  pipe_rx_os_top i_pipe_rx_os_top (
    .pipe_rx_usr_clk_i  (clk),
    .arst_n_i           (arst_n),
    .pipe_rxdata_i      (rxdata),
    .pipe_rxdatak_i     (rxdatak),
    .pipe_rxdata_valid_i(rxvalid),
    .phy_phystatus_i    (phystatus),
    .phy_rxstatus_i     (rxstatus),
    .os_ready_i         (os_ready),
    .os_valid_o         (os_valid),
    .os_kind_o          (os_kind),
    .os_link_num_o      (os_link),
    .os_lane_num_o      (os_lane),
    .os_rate_id_o       (os_rate),
    .os_train_ctrl_o    (os_train),
    .os_lane_mask_o     (os_mask),
    .ts1_valid_o        (ts1_valid),
    .ts2_valid_o        (ts2_valid),
    .idle_valid_o       (idle_valid),
    .lane_status_o      (lane_status),
    .num_active_lanes_o (num_active),
    .bad_count_o        (bad_count),
    .drop_count_o       (drop_count)
  );

  pipe_rx_os_checker i_checker (
    .pipe_rx_usr_clk_i  (clk),
    .os_valid_i         (os_valid),
    .os_ready_i         (os_ready),
    .os_kind_i          (os_kind),
    .os_fields_i        ({os_link, os_lane, os_rate, os_train}),
    .os_lane_mask_i     (os_mask),
    .ts1_valid_i        (ts1_valid),
    .ts2_valid_i        (ts2_valid),
    .idle_valid_i       (idle_valid),
    .lane_status_i      (lane_status),
    .num_active_lanes_i (num_active),
    .bad_count_i        (bad_count),
    .drop_count_i       (drop_count),
    .exp_push_i         (exp_push),
    .exp_name_i         (exp_name),
    .exp_kind_i         (exp_kind),
    .exp_fields_i       (exp_fields),
    .exp_mask_i         (exp_mask),
    .step_end_i         (step_end),
    .exp_pulses_i       (exp_pulses),
    .exp_status_i       (exp_status),
    .exp_nact_i         (exp_nact),
    .exp_bad_i          (exp_bad),
    .exp_drop_i         (exp_drop),
    .pending_o          (pending),
    .error_count_o      (check_errors)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic read_testdata();
    int    fd;
    int    n;
    string line;
    fd = $fopen("sim/pipe_rx_os_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      tb_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0) begin
          file_lines++;
        end
        if (n > 0 && line.len() > 1 && line[0] != 8'h23 && num_steps < max_steps) begin
          n = $sscanf(line, "%s %d %h %h %h %h %d %d %d %h %d %d",
                      st_name[num_steps], st_kind[num_steps], st_link[num_steps],
                      st_lane[num_steps], st_rate[num_steps], st_train[num_steps],
                      st_corrupt[num_steps], st_hold[num_steps], st_exp_kind[num_steps],
                      st_exp_mask[num_steps], st_d_bad[num_steps], st_d_drop[num_steps]);
          if (n == 12) begin
            num_steps++;
          end else begin
            $display("Malformed line in the test data file: %0s", line);
            tb_errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One clock of stimulus with one-cycle strobes
  task automatic drive_cycle(input sym_t [num_lanes-1:0] d, input lane_mask_t k,
                             input lane_mask_t v);
    @(posedge clk);
    #10;
    rxdata    = d;
    rxdatak   = k;
    rxvalid   = v;
    phystatus = '0;
    rxstatus  = '0;
    exp_push  = 1'b0;
    step_end  = 1'b0;
  endtask

  task automatic drive_filler();
    drive_cycle({num_lanes{filler}}, '0, '1);
  endtask

  task automatic send_ts(input int i, input int stall, input logic [7:0] link_ofs);
    sym_t [num_lanes-1:0] d;
    lane_mask_t           k;
    logic [7:0]           id;
    id = (st_kind[i] == 2) ? ts2_id : ts1_id;
    for (int p = 0; p < os_len; p++) begin
      k = '0;
      for (int l = 0; l < num_lanes; l++) begin
        case (p)
          0: begin
            d[l] = k_com;
            k[l] = 1'b1;
          end
          1: d[l] = st_link[i] + link_ofs;
          2: d[l] = st_lane[i] + 8'(l);
          3: d[l] = 8'h00;
          4: d[l] = st_rate[i];
          5: d[l] = st_train[i];
          default: d[l] = (p == 8 && l == st_corrupt[i]) ? 8'h11 : id;
        endcase
      end
      drive_cycle(d, k, '1);
      if (p == 7) begin
        repeat (stall) drive_cycle({num_lanes{filler}}, '0, '0);
      end
    end
  endtask

  // Idle data on lane 0 while the other lanes keep the filler
  task automatic send_idle(input int kind);
    int run;
    run = (kind == 3) ? idle_run_len : 5;
    repeat (run) drive_cycle({{(num_lanes-1){filler}}, 8'h00}, '0, '1);
    drive_filler();
    if (kind == 4) begin
      repeat (3) drive_cycle({{(num_lanes-1){filler}}, 8'h00}, '0, '1);
      drive_filler();
    end
  endtask

  task automatic run_step(input int i);
    int waited;
    int sets;
    int per_set;
    waited = 0;
    sets = (st_kind[i] == 7) ? 2 : 1;
    per_set = (st_corrupt[i] < num_lanes) ? num_lanes - 1 : num_lanes;
    repeat (1 + ($urandom % 3)) drive_filler();
    if (st_exp_kind[i] != 0) begin
      drive_filler();
      exp_push   = 1'b1;
      exp_name   = st_name[i];
      exp_kind   = 2'(st_exp_kind[i]);
      exp_fields = {st_link[i], st_lane[i], st_rate[i], st_train[i]};
      exp_mask   = st_exp_mask[i];
    end
    exp_pulses = '0;
    case (st_kind[i])
      1, 2, 6, 7: begin
        if (st_kind[i] == 7) begin
          os_ready = 1'b0;
        end
        // Each further set of a step carries the next link number
        for (int s = 0; s < sets; s++) begin
          send_ts(i, (st_kind[i] == 6) ? st_hold[i] : 0, 8'(s));
        end
        if (st_kind[i] == 7) begin
          repeat (st_hold[i]) drive_filler();
          os_ready = 1'b1;
        end
        if (st_kind[i] == 2) begin
          exp_pulses = 12'(sets * per_set) << 4;
        end else begin
          exp_pulses = 12'(sets * per_set) << 8;
        end
      end
      3, 4: begin
        send_idle(st_kind[i]);
        exp_pulses = (st_kind[i] == 3) ? 12'd1 : 12'd0;
      end
      default: begin
        drive_filler();
        phystatus[st_link[i][1:0]] = 1'b1;
        rxstatus[st_link[i][1:0]]  = st_lane[i][2:0];
        if (st_lane[i][2:0] == rxstatus_rx_detected) begin
          exp_status[st_link[i][1:0]] = 1'b1;
        end
      end
    endcase
    while (pending != 0 && waited < record_wait) begin
      drive_filler();
      waited++;
    end
    repeat (drain_cycles) drive_filler();
    exp_bad  = exp_bad + 8'(st_d_bad[i]);
    exp_drop = exp_drop + 8'(st_d_drop[i]);
    exp_nact = '0;
    for (int l = 0; l < num_lanes; l++) begin
      if (exp_status[l]) begin
        exp_nact = 3'(l + 1);
      end
    end
    drive_filler();
    step_end = 1'b1;
    exp_name = st_name[i];
  endtask

  initial begin
    void'($urandom(12));
    arst_n    = 1'b0;
    rxdata    = {num_lanes{filler}};
    rxdatak   = '0;
    rxvalid   = '0;
    phystatus = '0;
    rxstatus  = '0;
    os_ready  = 1'b1;
    exp_push  = 1'b0;
    exp_name  = '0;
    exp_kind  = '0;
    exp_fields = '0;
    exp_mask  = '0;
    step_end  = 1'b0;
    exp_pulses = '0;
    exp_status = '0;
    exp_nact  = '0;
    exp_bad   = '0;
    exp_drop  = '0;
    read_testdata();
    cycle_limit = 20 * file_lines + 100;
    repeat (3) @(posedge clk);
    #10;
    arst_n = 1'b1;
    for (int i = 0; i < num_steps; i++) begin
      run_step(i);
    end
    drive_filler();
    drive_filler();
    $display("Checker errors %0d, testbench errors %0d", check_errors, tb_errors);
    if (check_errors == 0 && tb_errors == 0 && num_steps > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/pipe_rx_os_testdata.txt
# name kind link lane rate train corrupt_lane hold exp_kind exp_mask d_bad d_drop
# kind 1 ts1, 2 ts2, 3 idle run, 4 broken idle run, 5 detect, 6 ts1 with valid gap,
# 7 two ts1 with ready low; a detect line puts the lane in link and rxstatus in lane
# corrupt_lane 4 means no lane is corrupted; exp_kind 0 means no record
ts1_all 1 01 10 02 07 4 0 1 f 0 0
ts2_all 2 05 20 04 08 4 0 2 f 0 0
idle_run 3 00 00 00 00 4 0 3 1 0 0
idle_short 4 00 00 00 00 4 0 0 0 0 0
ts1_bad_l2 1 02 30 02 01 2 0 1 b 1 0
ts2_bad_l0 2 03 40 02 02 0 0 0 0 1 0
ts1_hold 7 07 50 02 01 4 5 1 f 0 1
ts1_stall 6 01 10 02 07 4 3 1 f 0 0
det_l0 5 00 03 00 00 4 0 0 0 0 0
det_l3_other 5 03 02 00 00 4 0 0 0 0 0
det_l2 5 02 03 00 00 4 0 0 0 0 0
det_l1_other 5 01 04 00 00 4 0 0 0 0 0
det_l1 5 01 03 00 00 4 0 0 0 0 0
det_l3 5 03 03 00 00 4 0 0 0 0 0
ts2_after 2 09 60 02 03 4 0 2 f 0 0
